// File: hw/dma_defines.svh
/* Constants shared by the DMA timing core.
   Included by the package and by every module that sizes channel vectors. */
`ifndef DMA_DEFINES_SVH
`define DMA_DEFINES_SVH

`define DMA_CHANNELS        4
`define DMA_DATA_W          8
`define DMA_COUNT_W         8

// CPU register selects
`define DMA_SEL_COMMAND     2'd0
`define DMA_SEL_MODE        2'd1
`define DMA_SEL_COUNT       2'd2
`define DMA_SEL_CLEAR       2'd3

// Cycle state encodings
`define DMA_ST_IDLE         3'd0
`define DMA_ST_S0           3'd1
`define DMA_ST_S1           3'd2
`define DMA_ST_S2           3'd3
`define DMA_ST_S3           3'd4
`define DMA_ST_SW           3'd5
`define DMA_ST_S4           3'd6

`endif

// File: hw/dma_pkg.sv
/* Types shared by the DMA timing core.
   Modules refer to them by scoped name. */
`include "dma_defines.svh"

package dma_pkg;

    typedef enum logic [1:0] {
        XFER_VERIFY = 2'b00,
        XFER_WRITE  = 2'b01,
        XFER_READ   = 2'b10
    } xfer_type_e;

    // Cascade is reserved here and runs as single
    typedef enum logic [1:0] {
        MODE_DEMAND  = 2'b00,
        MODE_SINGLE  = 2'b01,
        MODE_BLOCK   = 2'b10,
        MODE_CASCADE = 2'b11
    } xfer_mode_e;

    typedef enum logic [2:0] {
        CS_IDLE = `DMA_ST_IDLE,
        CS_S0   = `DMA_ST_S0,
        CS_S1   = `DMA_ST_S1,
        CS_S2   = `DMA_ST_S2,
        CS_S3   = `DMA_ST_S3,
        CS_SW   = `DMA_ST_SW,
        CS_S4   = `DMA_ST_S4
    } cycle_state_e;

    typedef struct packed {
        logic       dack_high;
        logic       unused_6;
        logic       ext_write;
        logic       unused_4;
        logic       compressed;
        logic [2:0] unused_2_0;
    } command_word_t;

    typedef struct packed {
        xfer_mode_e mode;
        logic       decrement;
        logic       unused_4;
        xfer_type_e xtype;
        logic [1:0] chan;
    } mode_word_t;

    // One CPU byte, read as command or mode word by register select
    typedef union packed {
        command_word_t command;
        mode_word_t    mode;
    } prog_word_u;

    typedef struct packed {
        logic                   write;
        logic                   read;
        logic [1:0]             sel;
        logic [1:0]             chan;
        logic [`DMA_DATA_W-1:0] data;
    } cpu_bus_t;

    typedef struct packed {
        xfer_type_e xtype;
        xfer_mode_e mode;
        logic       tc;
    } chan_cfg_t;

    typedef struct packed {
        logic aen;
        logic memr_n;
        logic memw_n;
        logic ior_n;
        logic iow_n;
    } bus_strobe_t;

endpackage

// File: hw/dma_register_file.sv
/* CPU-programmed command, mode, count and status registers.
   Supplies the active channel's configuration and terminal count to the FSM. */
`timescale 1ns/10ps
`include "dma_defines.svh"

module dma_register_file (
    input  logic                        clock,
    input  logic                        reset,
    input  dma_pkg::cpu_bus_t           cpu_i,
    input  logic [1:0]                  chan_i,
    input  logic                        next_word_i,
    input  logic [`DMA_CHANNELS-1:0]    dreq_i,
    output dma_pkg::command_word_t      command_o,
    output dma_pkg::chan_cfg_t          cfg_o,
    output logic                        master_clear_o,
    output logic [7:0]                  status_o
);
    dma_pkg::prog_word_u        prog;
    dma_pkg::mode_word_t        mode_q [`DMA_CHANNELS];
    logic [`DMA_COUNT_W-1:0]    count_q [`DMA_CHANNELS];
    logic [`DMA_CHANNELS-1:0]   tc_flags_q;
    logic                       read_q;
    logic                       write_command;
    logic                       write_mode;
    logic                       write_count;
    logic                       terminal;

    assign prog           = cpu_i.data;
    assign write_command  = cpu_i.write && (cpu_i.sel == `DMA_SEL_COMMAND);
    assign write_mode     = cpu_i.write && (cpu_i.sel == `DMA_SEL_MODE);
    assign write_count    = cpu_i.write && (cpu_i.sel == `DMA_SEL_COUNT);
    assign master_clear_o = cpu_i.write && (cpu_i.sel == `DMA_SEL_CLEAR);

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            command_o <= '0;
        end else if (master_clear_o) begin
            command_o <= '0;
        end else if (write_command) begin
            command_o <= prog.command;
        end
    end

    // Mode word carries its own channel number
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `DMA_CHANNELS; i++) begin
                mode_q[i] <= '0;
            end
        end else if (master_clear_o) begin
            for (int i = 0; i < `DMA_CHANNELS; i++) begin
                mode_q[i] <= '0;
            end
        end else if (write_mode) begin
            mode_q[prog.mode.chan] <= prog.mode;
        end
    end

    // A CPU write wins over a decrement in the same cycle
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `DMA_CHANNELS; i++) begin
                count_q[i] <= '0;
            end
        end else if (write_count) begin
            count_q[cpu_i.chan] <= cpu_i.data;
        end else if (next_word_i) begin
            count_q[chan_i] <= count_q[chan_i] - 1'b1;
        end
    end

    // Count of zero marks the last transfer
    assign terminal = (count_q[chan_i] == '0);

    always_comb begin
        cfg_o.xtype = mode_q[chan_i].xtype;
        cfg_o.mode  = mode_q[chan_i].mode;
        cfg_o.tc    = terminal;
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            read_q <= 1'b0;
        end else begin
            read_q <= cpu_i.read;
        end
    end

    // Flags clear once the status read has ended
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            tc_flags_q <= '0;
        end else if (master_clear_o) begin
            tc_flags_q <= '0;
        end else if (read_q && !cpu_i.read) begin
            tc_flags_q <= '0;
        end else if (next_word_i && terminal) begin
            tc_flags_q[chan_i] <= 1'b1;
        end
    end

    assign status_o = cpu_i.read ? {dreq_i, tc_flags_q} : '0;

endmodule

// File: hw/dma_priority_arbiter.sv
/* Rotating-priority arbiter over the channel request lines.
   The channel served last drops to the lowest priority. */
`timescale 1ns/10ps
`include "dma_defines.svh"

module dma_priority_arbiter (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        master_clear_i,
    input  logic [`DMA_CHANNELS-1:0]    dreq_i,
    input  logic                        service_done_i,
    input  logic [1:0]                  served_chan_i,
    output logic [`DMA_CHANNELS-1:0]    grant_o
);
    logic [1:0] last_q;
    logic [1:0] idx;
    logic       found;

    // Channel 3 as last served puts channel 0 on top
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            last_q <= 2'd3;
        end else if (master_clear_i) begin
            last_q <= 2'd3;
        end else if (service_done_i) begin
            last_q <= served_chan_i;
        end
    end

    // Search upward from the channel after the last served, wrapping
    always_comb begin
        grant_o = '0;
        found   = 1'b0;
        idx     = last_q;
        for (int step = 1; step <= `DMA_CHANNELS; step++) begin
            idx = last_q + 2'(step);
            if (!found && dreq_i[idx]) begin
                grant_o[idx] = 1'b1;
                found        = 1'b1;
            end
        end
    end

endmodule

// File: hw/dma_cycle_fsm.sv
/* Bus request and transfer cycle state machine.
   Holds the serviced channel, pulses next_word in S4 and flags EOP at terminal count. */
`timescale 1ns/10ps
`include "dma_defines.svh"

module dma_cycle_fsm (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        master_clear_i,
    input  logic [`DMA_CHANNELS-1:0]    grant_i,
    input  logic [`DMA_CHANNELS-1:0]    dreq_i,
    input  logic                        hlda_i,
    input  logic                        ready_i,
    input  logic                        compressed_i,
    input  dma_pkg::chan_cfg_t          cfg_i,
    output dma_pkg::cycle_state_e       state_o,
    output logic [1:0]                  chan_o,
    output logic                        next_word_o,
    output logic                        service_done_o,
    output logic                        hrq_o,
    output logic                        eop_n_o
);
    dma_pkg::cycle_state_e  state_q;
    dma_pkg::cycle_state_e  state_d;
    logic [1:0]             chan_q;
    logic [1:0]             grant_chan;
    logic                   xfer_ready;
    logic                   last_word;

    // One-hot grant to channel number
    always_comb begin
        grant_chan = '0;
        for (int i = 0; i < `DMA_CHANNELS; i++) begin
            if (grant_i[i]) begin
                grant_chan = 2'(i);
            end
        end
    end

    // Verify cycles never wait on READY
    assign xfer_ready = ready_i || (cfg_i.xtype == dma_pkg::XFER_VERIFY);

    assign last_word = cfg_i.tc
                    || (cfg_i.mode == dma_pkg::MODE_SINGLE)
                    || (cfg_i.mode == dma_pkg::MODE_CASCADE)
                    || ((cfg_i.mode == dma_pkg::MODE_DEMAND) && !dreq_i[chan_q]);

    always_comb begin
        state_d = state_q;
        case (state_q)
            dma_pkg::CS_IDLE: begin
                if (grant_i != '0) begin
                    state_d = dma_pkg::CS_S0;
                end
            end
            dma_pkg::CS_S0: begin
                if (hlda_i) begin
                    state_d = dma_pkg::CS_S1;
                end
            end
            dma_pkg::CS_S1: begin
                state_d = dma_pkg::CS_S2;
            end
            dma_pkg::CS_S2: begin
                if (!compressed_i) begin
                    state_d = dma_pkg::CS_S3;
                end else begin
                    state_d = xfer_ready ? dma_pkg::CS_S4 : dma_pkg::CS_SW;
                end
            end
            dma_pkg::CS_S3: begin
                state_d = xfer_ready ? dma_pkg::CS_S4 : dma_pkg::CS_SW;
            end
            dma_pkg::CS_SW: begin
                if (ready_i) begin
                    state_d = dma_pkg::CS_S4;
                end
            end
            dma_pkg::CS_S4: begin
                state_d = last_word ? dma_pkg::CS_IDLE : dma_pkg::CS_S2;
            end
            default: begin
                state_d = dma_pkg::CS_IDLE;
            end
        endcase
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            state_q <= dma_pkg::CS_IDLE;
        end else if (master_clear_i) begin
            state_q <= dma_pkg::CS_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Channel is fixed for the whole service
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            chan_q <= '0;
        end else if (master_clear_i) begin
            chan_q <= '0;
        end else if ((state_q == dma_pkg::CS_IDLE) && (grant_i != '0)) begin
            chan_q <= grant_chan;
        end
    end

    assign state_o        = state_q;
    assign chan_o         = chan_q;
    assign hrq_o          = (state_q != dma_pkg::CS_IDLE);
    assign next_word_o    = (state_q == dma_pkg::CS_S4);
    assign eop_n_o        = !(next_word_o && cfg_i.tc);
    assign service_done_o = next_word_o && (state_d == dma_pkg::CS_IDLE);

endmodule

// File: hw/dma_strobe_gen.sv
/* Registered AEN, DACK and bus strobes decoded from the cycle state.
   Outputs trail the state by one clock; DACK polarity comes from the command word. */
`timescale 1ns/10ps
`include "dma_defines.svh"

module dma_strobe_gen (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        master_clear_i,
    input  dma_pkg::cycle_state_e       state_i,
    input  logic [1:0]                  chan_i,
    input  dma_pkg::xfer_type_e         type_i,
    input  dma_pkg::command_word_t      command_i,
    output dma_pkg::bus_strobe_t        strobe_o,
    output logic [`DMA_CHANNELS-1:0]    dack_o
);
    dma_pkg::bus_strobe_t       strobe_d;
    logic [`DMA_CHANNELS-1:0]   dack_d;
    logic [`DMA_CHANNELS-1:0]   dack_q;
    logic                       aen_on;
    logic                       read_on;
    logic                       write_on;

    always_comb begin
        aen_on   = (state_i != dma_pkg::CS_IDLE) && (state_i != dma_pkg::CS_S0);
        read_on  = (state_i == dma_pkg::CS_S2) || (state_i == dma_pkg::CS_S3)
                || (state_i == dma_pkg::CS_SW);
        // Early write in S2 for extended write or compressed timing
        write_on = (state_i == dma_pkg::CS_S3) || (state_i == dma_pkg::CS_SW)
                || ((state_i == dma_pkg::CS_S2)
                    && (command_i.ext_write || command_i.compressed));

        strobe_d.aen    = aen_on;
        strobe_d.memr_n = !(read_on && (type_i == dma_pkg::XFER_READ));
        strobe_d.ior_n  = !(read_on && (type_i == dma_pkg::XFER_WRITE));
        strobe_d.memw_n = !(write_on && (type_i == dma_pkg::XFER_WRITE));
        strobe_d.iow_n  = !(write_on && (type_i == dma_pkg::XFER_READ));

        dack_d         = '0;
        dack_d[chan_i] = aen_on && (state_i != dma_pkg::CS_S1);

        if (master_clear_i) begin
            strobe_d = '{aen: 1'b0, memr_n: 1'b1, memw_n: 1'b1, ior_n: 1'b1, iow_n: 1'b1};
            dack_d   = '0;
        end
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            strobe_o <= '{aen: 1'b0, memr_n: 1'b1, memw_n: 1'b1, ior_n: 1'b1, iow_n: 1'b1};
            dack_q   <= '0;
        end else begin
            strobe_o <= strobe_d;
            dack_q   <= dack_d;
        end
    end

    assign dack_o = command_i.dack_high ? dack_q : ~dack_q;

endmodule

// File: hw/dma_controller.sv
/* Top level of the four-channel DMA timing core.
   Connects the register file, arbiter, cycle FSM and strobe generator. */
`timescale 1ns/10ps
`include "dma_defines.svh"

module dma_controller (
    input  logic                        clock,
    input  logic                        reset,
    input  dma_pkg::cpu_bus_t           cpu_i,
    input  logic [`DMA_CHANNELS-1:0]    dreq_i,
    input  logic                        hlda_i,
    input  logic                        ready_i,
    output logic                        hrq_o,
    output logic [`DMA_CHANNELS-1:0]    dack_o,
    output dma_pkg::bus_strobe_t        strobe_o,
    output logic                        eop_n_o,
    output logic [7:0]                  status_o
);
    dma_pkg::command_word_t     command;
    dma_pkg::chan_cfg_t         cfg;
    dma_pkg::cycle_state_e      state;
    logic                       master_clear;
    logic                       next_word;
    logic                       service_done;
    logic [1:0]                 chan;
    logic [`DMA_CHANNELS-1:0]   grant;

    dma_register_file i_register_file (
        .clock          (clock),
        .reset          (reset),
        .cpu_i          (cpu_i),
        .chan_i         (chan),
        .next_word_i    (next_word),
        .dreq_i         (dreq_i),
        .command_o      (command),
        .cfg_o          (cfg),
        .master_clear_o (master_clear),
        .status_o       (status_o)
    );

    dma_priority_arbiter i_priority_arbiter (
        .clock          (clock),
        .reset          (reset),
        .master_clear_i (master_clear),
        .dreq_i         (dreq_i),
        .service_done_i (service_done),
        .served_chan_i  (chan),
        .grant_o        (grant)
    );

    dma_cycle_fsm i_cycle_fsm (
        .clock          (clock),
        .reset          (reset),
        .master_clear_i (master_clear),
        .grant_i        (grant),
        .dreq_i         (dreq_i),
        .hlda_i         (hlda_i),
        .ready_i        (ready_i),
        .compressed_i   (command.compressed),
        .cfg_i          (cfg),
        .state_o        (state),
        .chan_o         (chan),
        .next_word_o    (next_word),
        .service_done_o (service_done),
        .hrq_o          (hrq_o),
        .eop_n_o        (eop_n_o)
    );

    dma_strobe_gen i_strobe_gen (
        .clock          (clock),
        .reset          (reset),
        .master_clear_i (master_clear),
        .state_i        (state),
        .chan_i         (chan),
        .type_i         (cfg.xtype),
        .command_i      (command),
        .strobe_o       (strobe_o),
        .dack_o         (dack_o)
    );

endmodule

// File: dv/dma_tb.sv
/* Testbench for the DMA timing core: programs channels over the CPU port,
   models the host HLDA response and checks bus timing with concurrent assertions. */
`timescale 1ns/10ps
`include "dma_defines.svh"

module dma_tb;
    logic                       clock = 1'b0;
    logic                       reset;
    dma_pkg::cpu_bus_t          cpu_i;
    logic [`DMA_CHANNELS-1:0]   dreq_i;
    logic                       hlda_i = 1'b0;
    logic                       ready_i = 1'b1;
    logic                       hrq_o;
    logic [`DMA_CHANNELS-1:0]   dack_o;
    dma_pkg::bus_strobe_t       strobe_o;
    logic                       eop_n_o;
    logic [7:0]                 status_o;

    int                         errors = 0;
    int                         cycles = 0;
    int                         hdelay = 2;
    int                         wpulses = 0;
    int                         eops = 0;
    int                         busy = 0;
    int                         svc_count = 0;
    int                         exp_w = -1;
    int                         exp_eop = 0;
    int                         exp_busy = 0;
    logic                       chk_on = 1'b0;
    logic                       rot_on = 1'b0;
    logic                       ready_rand = 1'b0;
    logic                       dack_high_exp = 1'b0;
    logic                       early_exp = 1'b0;
    logic [3:0]                 exp_tc = 4'h0;
    logic [3:0]                 req_mask = 4'h0;
    logic [3:0]                 last_act = 4'b1000;
    logic                       hrq_q = 1'b0;
    logic                       wlow_q = 1'b0;
    logic                       eop_q = 1'b1;
    logic [3:0]                 act_q = 4'h0;
    dma_pkg::xfer_type_e        cur_xtype = dma_pkg::XFER_WRITE;

    logic       wlow;
    logic       clear_wr;
    logic       quiet;
    logic       bus_free;
    logic [3:0] dack_idle;
    logic [3:0] dack_act;

    dma_controller i_dut (
        .clock    (clock),
        .reset    (reset),
        .cpu_i    (cpu_i),
        .dreq_i   (dreq_i),
        .hlda_i   (hlda_i),
        .ready_i  (ready_i),
        .hrq_o    (hrq_o),
        .dack_o   (dack_o),
        .strobe_o (strobe_o),
        .eop_n_o  (eop_n_o),
        .status_o (status_o)
    );

    initial begin
        forever #4 clock = ~clock;
    end

    assign wlow      = !strobe_o.memw_n || !strobe_o.iow_n;
    assign clear_wr  = cpu_i.write && (cpu_i.sel == `DMA_SEL_CLEAR);
    assign dack_idle = dack_high_exp ? 4'h0 : 4'hf;
    assign dack_act  = dack_o ^ dack_idle;
    assign bus_free  = !strobe_o.aen && strobe_o.memr_n && strobe_o.memw_n
                    && strobe_o.ior_n && strobe_o.iow_n && (dack_o == dack_idle);
    assign quiet     = !hrq_o && eop_n_o && (dack_o == 4'hf) && !strobe_o.aen
                    && strobe_o.memr_n && strobe_o.memw_n && strobe_o.ior_n && strobe_o.iow_n;

    // Host side of HRQ/HLDA with 1 to 4 cycles of grant latency
    always @(posedge clock) begin
        if (reset) begin
            hlda_i <= 1'b0;
        end else if (!hlda_i) begin
            if (hrq_o) begin
                if (hdelay == 0) begin
                    hlda_i <= 1'b1;
                end else begin
                    hdelay <= hdelay - 1;
                end
            end
        end else if (!hrq_o) begin
            hlda_i <= 1'b0;
            hdelay <= $urandom_range(3, 0);
        end
    end

    // READY mostly low while wait states are exercised
    always @(posedge clock) begin
        ready_i <= ready_rand ? ($urandom_range(3, 0) == 0) : 1'b1;
    end

    // Expected command options tracked from CPU writes
    always @(posedge clock) begin
        if (reset || clear_wr) begin
            dack_high_exp <= 1'b0;
            early_exp     <= 1'b0;
        end else if (cpu_i.write && (cpu_i.sel == `DMA_SEL_COMMAND)) begin
            dack_high_exp <= cpu_i.data[7];
            early_exp     <= cpu_i.data[3] || cpu_i.data[5];
        end
    end

    // Per-service pulse and cycle counts
    always @(posedge clock) begin
        hrq_q  <= hrq_o;
        wlow_q <= wlow;
        eop_q  <= eop_n_o;
        act_q  <= dack_act;
        if (hrq_o && !hrq_q) begin
            wpulses <= 0;
            eops    <= 0;
            busy    <= 0;
        end else begin
            if (wlow && !wlow_q) begin
                wpulses <= wpulses + 1;
            end
            if (!eop_n_o && eop_q) begin
                eops <= eops + 1;
            end
            if (hrq_o && hlda_i) begin
                busy <= busy + 1;
            end
        end
        if (!hrq_o && hrq_q) begin
            svc_count <= svc_count + 1;
        end
        if ((dack_act != 4'h0) && (act_q == 4'h0)) begin
            last_act <= dack_act;
        end
        cycles <= cycles + 1;
        if (cycles >= 3000) begin
            $display("Timeout: the test sequence did not finish within 3000 cycles");
            $display("ERRORS FOUND");
            $finish;
        end
    end

    a_reset: assert property (@(posedge clock) (reset && $past(reset)) |-> quiet)
        else begin
            errors++;
            $display("[ERROR] reset outputs hrq_o=%h strobe_o=%h dack_o=%h",
                hrq_o, strobe_o, dack_o);
        end
    a_clear: assert property (@(posedge clock) disable iff (reset) $past(clear_wr) |-> quiet)
        else begin
            errors++;
            $display("[ERROR] clear outputs hrq_o=%h strobe_o=%h dack_o=%h",
                hrq_o, strobe_o, dack_o);
        end
    a_hlda: assert property (@(posedge clock) disable iff (reset) !hlda_i |-> bus_free)
        else begin
            errors++;
            $display("[ERROR] bus without hlda_i strobe_o=%h dack_o=%h", strobe_o, dack_o);
        end
    a_dack: assert property (@(posedge clock) disable iff (reset)
        (!strobe_o.ior_n || !strobe_o.memr_n)
        |-> ($onehot(dack_act) && ((dack_act & req_mask) != 4'h0)))
        else begin
            errors++;
            $display("[ERROR] read strobe with dack_o=%h requests %h", dack_o, req_mask);
        end
    a_nest: assert property (@(posedge clock) disable iff (reset)
        (strobe_o.memw_n || !strobe_o.ior_n) && (strobe_o.iow_n || !strobe_o.memr_n))
        else begin
            errors++;
            $display("[ERROR] write outside read strobe_o=%h", strobe_o);
        end
    a_type: assert property (@(posedge clock) disable iff (reset)
        ((cur_xtype == dma_pkg::XFER_WRITE) ? (strobe_o.memr_n && strobe_o.iow_n) :
         (cur_xtype == dma_pkg::XFER_READ) ? (strobe_o.memw_n && strobe_o.ior_n) :
         (strobe_o.memr_n && strobe_o.iow_n && strobe_o.memw_n && strobe_o.ior_n)))
        else begin
            errors++;
            $display("[ERROR] wrong strobe for type strobe_o=%h", strobe_o);
        end
    a_early: assert property (@(posedge clock) disable iff (reset)
        ($fell(strobe_o.ior_n) || $fell(strobe_o.memr_n)) |-> (wlow == early_exp))
        else begin
            errors++;
            $display("[ERROR] first read cycle strobe_o=%h expected early=%h",
                strobe_o, early_exp);
        end
    a_ready: assert property (@(posedge clock) disable iff (reset)
        ((cur_xtype == dma_pkg::XFER_WRITE) && !ready_i && !$past(ready_i) && !strobe_o.ior_n)
        |=> (!strobe_o.ior_n && !strobe_o.memw_n))
        else begin
            errors++;
            $display("[ERROR] strobe released in wait strobe_o=%h", strobe_o);
        end
    a_eop: assert property (@(posedge clock) disable iff (reset)
        (!eop_n_o && (cur_xtype != dma_pkg::XFER_VERIFY)) |-> wlow)
        else begin
            errors++;
            $display("[ERROR] eop_n_o outside write strobe_o=%h", strobe_o);
        end
    a_service: assert property (@(posedge clock) disable iff (reset) (chk_on && $fell(hrq_o))
        |-> ((exp_w < 0) || (wpulses == exp_w)) && (eops == exp_eop)
            && ((exp_busy == 0) || (busy == exp_busy)))
        else begin
            errors++;
            $display("[ERROR] service wpulses=%h eops=%h busy=%h expected %h %h %h",
                wpulses, eops, busy, exp_w, exp_eop, exp_busy);
        end
    a_status: assert property (@(posedge clock) disable iff (reset)
        cpu_i.read |-> (status_o == {dreq_i, exp_tc}))
        else begin
            errors++;
            $display("[ERROR] status_o=%h expected %h", status_o, {dreq_i, exp_tc});
        end
    a_rotate: assert property (@(posedge clock) disable iff (reset)
        (rot_on && (dack_act != 4'h0) && ($past(dack_act) == 4'h0)) |-> (dack_act != last_act))
        else begin
            errors++;
            $display("[ERROR] channel served twice dack_o=%h", dack_o);
        end

    function automatic logic [7:0] mode_byte(input logic [1:0] ch,
                                             input dma_pkg::xfer_type_e t,
                                             input dma_pkg::xfer_mode_e m);
        mode_byte = {m, 2'b00, t, ch};
    endfunction

    task automatic write_reg(input logic [1:0] sel, input logic [1:0] ch, input logic [7:0] d);
        @(posedge clock);
        cpu_i <= '{write: 1'b1, read: 1'b0, sel: sel, chan: ch, data: d};
        @(posedge clock);
        cpu_i.write <= 1'b0;
    endtask

    task automatic settle();
        int idle_cycles;
        idle_cycles = 0;
        while (idle_cycles < 4) begin
            @(posedge clock);
            idle_cycles = hrq_o ? 0 : idle_cycles + 1;
        end
    endtask

    // One request that drops as soon as the bus is requested
    task automatic serve(input int ch);
        int target;
        target = svc_count + 1;
        @(posedge clock);
        req_mask = 4'(1 << ch);
        dreq_i[ch] <= 1'b1;
        while (!hrq_o) @(posedge clock);
        dreq_i[ch] <= 1'b0;
        while (svc_count < target) @(posedge clock);
        settle();
    endtask

    task automatic read_status(input logic [3:0] flags);
        @(posedge clock);
        cpu_i.read <= 1'b1;
        exp_tc     <= flags;
        repeat (2) @(posedge clock);
        cpu_i.read <= 1'b0;
        @(posedge clock);
        cpu_i.read <= 1'b1;
        exp_tc     <= 4'h0;
        repeat (2) @(posedge clock);
        cpu_i.read <= 1'b0;
    endtask

    initial begin
        int target;
        void'($urandom(32'h94ff9983));
        reset  = 1'b1;
        cpu_i  = '0;
        dreq_i = '0;
        repeat (16) @(posedge clock);
        reset <= 1'b0;
        write_reg(`DMA_SEL_CLEAR, 2'd0, 8'h00);
        settle();

        // Single write on channel 2
        write_reg(`DMA_SEL_MODE, 2'd0, mode_byte(2'd2, dma_pkg::XFER_WRITE, dma_pkg::MODE_SINGLE));
        write_reg(`DMA_SEL_COUNT, 2'd2, 8'd20);
        exp_w   = 1;
        exp_eop = 0;
        chk_on  = 1'b1;
        repeat (3) serve(2);

        // Block read of N = 4 on channel 1
        write_reg(`DMA_SEL_MODE, 2'd0, mode_byte(2'd1, dma_pkg::XFER_READ, dma_pkg::MODE_BLOCK));
        write_reg(`DMA_SEL_COUNT, 2'd1, 8'd4);
        cur_xtype = dma_pkg::XFER_READ;
        exp_w     = 5;
        exp_eop   = 1;
        serve(1);
        read_status(4'b0010);

        // Block write with READY wait states, then block verify
        write_reg(`DMA_SEL_MODE, 2'd0, mode_byte(2'd0, dma_pkg::XFER_WRITE, dma_pkg::MODE_BLOCK));
        write_reg(`DMA_SEL_COUNT, 2'd0, 8'd3);
        write_reg(`DMA_SEL_MODE, 2'd0, mode_byte(2'd3, dma_pkg::XFER_VERIFY, dma_pkg::MODE_BLOCK));
        write_reg(`DMA_SEL_COUNT, 2'd3, 8'd2);
        cur_xtype  = dma_pkg::XFER_WRITE;
        exp_w      = 4;
        ready_rand <= 1'b1;
        serve(0);
        cur_xtype = dma_pkg::XFER_VERIFY;
        exp_w     = 0;
        exp_busy  = 11;
        serve(3);
        ready_rand <= 1'b0;
        exp_busy   = 0;
        settle();
        read_status(4'b1001);

        // Rotation between channels 0 and 3
        write_reg(`DMA_SEL_CLEAR, 2'd0, 8'h00);
        write_reg(`DMA_SEL_MODE, 2'd0, mode_byte(2'd0, dma_pkg::XFER_WRITE, dma_pkg::MODE_SINGLE));
        write_reg(`DMA_SEL_MODE, 2'd0, mode_byte(2'd3, dma_pkg::XFER_WRITE, dma_pkg::MODE_SINGLE));
        write_reg(`DMA_SEL_COUNT, 2'd0, 8'd50);
        write_reg(`DMA_SEL_COUNT, 2'd3, 8'd50);
        cur_xtype = dma_pkg::XFER_WRITE;
        exp_w     = 1;
        exp_eop   = 0;
        rot_on    = 1'b1;
        target    = svc_count + 6;
        @(posedge clock);
        req_mask = 4'b1001;
        dreq_i <= 4'b1001;
        // Status carries the live request lines
        read_status(4'h0);
        while (svc_count < target) @(posedge clock);
        dreq_i <= 4'b0000;
        settle();
        rot_on = 1'b0;

        // DACK active high, then compressed timing
        write_reg(`DMA_SEL_COMMAND, 2'd0, 8'h80);
        serve(3);
        write_reg(`DMA_SEL_COMMAND, 2'd0, 8'h08);
        serve(3);

        // Demand mode ends when the request drops
        write_reg(`DMA_SEL_COMMAND, 2'd0, 8'h00);
        write_reg(`DMA_SEL_MODE, 2'd0, mode_byte(2'd1, dma_pkg::XFER_WRITE, dma_pkg::MODE_DEMAND));
        write_reg(`DMA_SEL_COUNT, 2'd1, 8'd100);
        exp_w  = -1;
        target = svc_count + 1;
        @(posedge clock);
        req_mask = 4'b0010;
        dreq_i[1] <= 1'b1;
        while (!hrq_o) @(posedge clock);
        repeat (20) @(posedge clock);
        dreq_i[1] <= 1'b0;
        while (svc_count < target) @(posedge clock);
        settle();

        // Master clear in the middle of a demand service with DACK active high
        write_reg(`DMA_SEL_COMMAND, 2'd0, 8'h80);
        @(posedge clock);
        dreq_i[1] <= 1'b1;
        while (!hrq_o) @(posedge clock);
        repeat (10) @(posedge clock);
        write_reg(`DMA_SEL_CLEAR, 2'd0, 8'h00);
        dreq_i[1] <= 1'b0;
        settle();

        $display("Run finished with %0d errors after %0d cycles", errors, cycles);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: list.f
+incdir+hw
hw/dma_pkg.sv
hw/dma_register_file.sv
hw/dma_priority_arbiter.sv
hw/dma_cycle_fsm.sv
hw/dma_strobe_gen.sv
hw/dma_controller.sv
dv/dma_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build the DMA testbench with Verilator, run it and report the result
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -f list.f --top-module dma_tb \
        -Mdir obj_dir -o dma_sim \
    && ./obj_dir/dma_sim | tee /dev/stderr | grep -qx "NO ERRORS" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
